// ==== build.f ====
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/instr_decoder.sv
hw/control_sequencer.sv
hw/control_word_encoder.sv
hw/mips_control_top.sv
tb/tb_clock_gen.sv
tb/mips_control_chk.sv
tb/tb_mips_control.sv

// ==== Makefile ====
TOP       ?= tb_mips_control
SEED      ?= 32'hbbc60a5b
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir

VFLAGS = --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) "-GSEED=$(SEED)"

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f build.f

run: compile
	$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_mips_control.sv ====
module tb_mips_control #(
    parameter logic [31:0] SEED = 32'hbbc60a5b
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WAIT   = 2;
    localparam int EXC_WAIT   = 3;
    localparam int N_UNDEF    = 4;
    localparam int NUM_TESTS  = N_UNDEF + 6;
    localparam int CLK_PERIOD = 100;

    logic                      clk;
    logic                      reset;
    mips_isa_pkg::opcode_t     opcode;
    mips_isa_pkg::funct_t      funct;
    logic                      ov;
    mips_ctrl_pkg::ctrl_word_t ctrl;

    logic [31:0] lcg_state;
    int          test_errors;
    int          chk_base;
    int          tests_run;
    int          tests_failed;
    int          total_errors;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (4)
    ) i_clock (
        .clk   (clk),
        .reset (reset)
    );

    mips_control_top #(
        .MEM_WAIT (MEM_WAIT),
        .EXC_WAIT (EXC_WAIT)
    ) i_dut (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ov     (ov),
        .ctrl   (ctrl)
    );

    bind mips_control_top mips_control_chk i_chk (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_legal(input mips_isa_pkg::opcode_t opc,
                                      input mips_isa_pkg::funct_t fn);
        return opc == mips_isa_pkg::OP_RTYPE && (fn == mips_isa_pkg::FN_ADD
            || fn == mips_isa_pkg::FN_SUB || fn == mips_isa_pkg::FN_AND);
    endfunction

    // Stack pointer load, all other fields zero
    function automatic mips_ctrl_pkg::ctrl_word_t stack_init_word();
        mips_ctrl_pkg::ctrl_word_t w;
        w           = '0;
        w.reg_write = 1'b1;
        w.reg_dst   = mips_ctrl_pkg::dst_sp;
        w.mem_toreg = mips_ctrl_pkg::wb_stack_top;
        return w;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic expect_val(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERR %t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic begin_test();
        test_errors = 0;
        chk_base    = i_dut.i_chk.fail_count;
    endtask

    task automatic end_test(input string name);
        int asrt_fails;
        asrt_fails = i_dut.i_chk.fail_count - chk_base;
        tests_run++;
        if (test_errors == 0 && asrt_fails == 0) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            total_errors += test_errors + asrt_fails;
            $display("test %s failed with %0d mismatches and %0d assertion failures",
                     name, test_errors, asrt_fails);
        end
    endtask

    task automatic check_fetch0();
        expect_val("ir_write", 0, int'(ctrl.ir_write));
        expect_val("iord", int'(mips_ctrl_pkg::iord_pc), int'(ctrl.iord));
        expect_val("alu_srca", int'(mips_ctrl_pkg::srca_pc), int'(ctrl.alu_srca));
        expect_val("alu_srcb", int'(mips_ctrl_pkg::srcb_four), int'(ctrl.alu_srcb));
        expect_val("alu_op", int'(mips_ctrl_pkg::alu_add), int'(ctrl.alu_op));
    endtask

    // Starts on the first fetch0 cycle, returns on the decode cycle
    task automatic do_fetch();
        for (int i = 0; i < MEM_WAIT; i++) begin
            check_fetch0();
            next_cycle();
        end
        expect_val("ir_write", 1, int'(ctrl.ir_write));
        expect_val("pc_write", 1, int'(ctrl.pc_write));
        next_cycle();
        expect_val("a_write", 1, int'(ctrl.a_write));
        expect_val("b_write", 1, int'(ctrl.b_write));
        expect_val("alu_srcb", int'(mips_ctrl_pkg::srcb_offset), int'(ctrl.alu_srcb));
        expect_val("alu_op", int'(mips_ctrl_pkg::alu_add), int'(ctrl.alu_op));
        expect_val("alu_reg_write", 0, int'(ctrl.alu_reg_write));
    endtask

    // Starts on the first exception-wait cycle
    task automatic check_exception(input mips_ctrl_pkg::exc_code_t code);
        for (int i = 0; i < EXC_WAIT; i++) begin
            expect_val("iord", int'(mips_ctrl_pkg::iord_vector), int'(ctrl.iord));
            expect_val("except", int'(code), int'(ctrl.except));
            expect_val("alu_op", int'(mips_ctrl_pkg::alu_sub), int'(ctrl.alu_op));
            expect_val("alu_reg_write", 0, int'(ctrl.alu_reg_write));
            next_cycle();
        end
        expect_val("epc_write", 1, int'(ctrl.epc_write));
        expect_val("pc_write", 1, int'(ctrl.pc_write));
        expect_val("pc_src", int'(mips_ctrl_pkg::pcsrc_vector), int'(ctrl.pc_src));
        next_cycle();
        check_fetch0();
    endtask

    task automatic run_legal(input string name, input mips_isa_pkg::funct_t fn,
                             input mips_ctrl_pkg::alu_op_t exp_alu, input logic ov_val,
                             input logic swap_lines);
        begin_test();
        opcode = mips_isa_pkg::OP_RTYPE;
        funct  = fn;
        do_fetch();
        next_cycle();
        expect_val("alu_op", int'(exp_alu), int'(ctrl.alu_op));
        expect_val("alu_reg_write", 1, int'(ctrl.alu_reg_write));
        expect_val("alu_srca", int'(mips_ctrl_pkg::srca_a), int'(ctrl.alu_srca));
        ov = ov_val;
        if (swap_lines) begin
            // Load opcode, not implemented here
            opcode = 6'h23;
            funct  = lcg_state[5:0];
            #1;
            expect_val("alu_op", int'(exp_alu), int'(ctrl.alu_op));
        end
        next_cycle();
        if (ov_val) begin
            expect_val("reg_write", 0, int'(ctrl.reg_write));
            // Overflow has to be seen for the whole write-back cycle
            next_cycle();
            ov = 1'b0;
            check_exception(mips_ctrl_pkg::exc_overflow);
        end else begin
            expect_val("reg_write", 1, int'(ctrl.reg_write));
            expect_val("reg_dst", int'(mips_ctrl_pkg::dst_rd), int'(ctrl.reg_dst));
            expect_val("mem_toreg", int'(mips_ctrl_pkg::wb_alu), int'(ctrl.mem_toreg));
            next_cycle();
            check_fetch0();
        end
        end_test(name);
    endtask

    task automatic run_undef(input string name);
        mips_isa_pkg::opcode_t opc;
        mips_isa_pkg::funct_t  fn;
        begin_test();
        do begin
            lcg_state = lcg_next(lcg_state);
            opc       = lcg_state[8] ? mips_isa_pkg::OP_RTYPE : lcg_state[31:26];
            fn        = lcg_state[21:16];
        end while (is_legal(opc, fn));
        opcode = opc;
        funct  = fn;
        do_fetch();
        next_cycle();
        check_exception(mips_ctrl_pkg::exc_noopcode);
        end_test(name);
    endtask

    initial begin
        #(NUM_TESTS * 20 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", NUM_TESTS * 20);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        opcode       = mips_isa_pkg::OP_RTYPE;
        funct        = mips_isa_pkg::FN_ADD;
        ov           = 1'b0;
        lcg_state    = SEED;
        test_errors  = 0;
        chk_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;

        begin_test();
        @(posedge clk);
        repeat (3) begin
            next_cycle();
            expect_val("ctrl", int'(stack_init_word()), int'(ctrl));
        end
        @(negedge reset);
        next_cycle();
        check_fetch0();
        expect_val("reg_write", 0, int'(ctrl.reg_write));
        end_test("reset");

        run_legal("add", mips_isa_pkg::FN_ADD, mips_ctrl_pkg::alu_add, 1'b0, 1'b0);
        run_legal("sub", mips_isa_pkg::FN_SUB, mips_ctrl_pkg::alu_sub, 1'b0, 1'b0);
        run_legal("and", mips_isa_pkg::FN_AND, mips_ctrl_pkg::alu_and, 1'b0, 1'b0);
        run_legal("overflow", mips_isa_pkg::FN_ADD, mips_ctrl_pkg::alu_add, 1'b1, 1'b0);
        for (int i = 0; i < N_UNDEF; i++) begin
            run_undef($sformatf("undef_%0d", i));
        end
        run_legal("late_change", mips_isa_pkg::FN_SUB, mips_ctrl_pkg::alu_sub, 1'b0, 1'b1);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/mips_control_chk.sv ====
module mips_control_chk (
    input logic                      clk,
    input logic                      reset,
    input mips_ctrl_pkg::ctrl_word_t ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // IR load comes with the PC+4 write
    ir_with_pc: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_write |-> ctrl.pc_write)
    else begin
        fail_count++;
        $error("ir_write without pc_write");
    end

    ir_then_regs: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_write |=> ctrl.a_write && ctrl.b_write)
    else begin
        fail_count++;
        $error("a_write and b_write missing after ir_write");
    end

    exec_then_rd: assert property (@(posedge clk) disable iff (reset)
        ctrl.alu_reg_write |=> !ctrl.reg_write || ctrl.reg_dst == mips_ctrl_pkg::dst_rd)
    else begin
        fail_count++;
        $error("write-back after execute not aimed at rd");
    end

    // Dropped write-back has to lead into the exception wait
    skipped_wb_exc: assert property (@(posedge clk) disable iff (reset)
        $past(ctrl.alu_reg_write) && !ctrl.reg_write |=> ctrl.iord == mips_ctrl_pkg::iord_vector)
    else begin
        fail_count++;
        $error("no exception wait after a dropped write-back");
    end

    epc_with_vector: assert property (@(posedge clk) disable iff (reset)
        ctrl.epc_write |-> ctrl.pc_src == mips_ctrl_pkg::pcsrc_vector)
    else begin
        fail_count++;
        $error("epc_write without the vector PC source");
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Released on a falling edge like every other DUT input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== hw/mips_control_top.sv ====
module mips_control_top #(
    parameter int MEM_WAIT = 2,
    parameter int EXC_WAIT = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  mips_isa_pkg::opcode_t     opcode,
    input  mips_isa_pkg::funct_t      funct,
    input  logic                      ov,
    output mips_ctrl_pkg::ctrl_word_t ctrl
);

    mips_isa_pkg::op_kind_t kind;
    mips_isa_pkg::op_kind_t exec_kind;
    mips_ctrl_pkg::state_t  state;
    mips_ctrl_pkg::exc_t    exc;

    instr_decoder i_decoder (
        .opcode (opcode),
        .funct  (funct),
        .kind   (kind)
    );

    control_sequencer #(
        .MEM_WAIT (MEM_WAIT),
        .EXC_WAIT (EXC_WAIT)
    ) i_sequencer (
        .clk       (clk),
        .reset     (reset),
        .kind      (kind),
        .ov        (ov),
        .state     (state),
        .exc       (exc),
        .exec_kind (exec_kind)
    );

    control_word_encoder i_encoder (
        .state (state),
        .kind  (exec_kind),
        .exc   (exc),
        .ctrl  (ctrl)
    );

endmodule

// ==== hw/control_word_encoder.sv ====
module control_word_encoder (
    input  mips_ctrl_pkg::state_t     state,
    input  mips_isa_pkg::op_kind_t    kind,
    input  mips_ctrl_pkg::exc_t       exc,
    output mips_ctrl_pkg::ctrl_word_t ctrl
);

    always_comb begin
        ctrl = '0;
        case (state)
            mips_ctrl_pkg::st_reset: begin
                // Load the stack pointer with its initial value
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = mips_ctrl_pkg::dst_sp;
                ctrl.mem_toreg = mips_ctrl_pkg::wb_stack_top;
            end
            mips_ctrl_pkg::st_fetch0: begin
                ctrl.iord     = mips_ctrl_pkg::iord_pc;
                ctrl.alu_srca = mips_ctrl_pkg::srca_pc;
                ctrl.alu_srcb = mips_ctrl_pkg::srcb_four;
                ctrl.alu_op   = mips_ctrl_pkg::alu_add;
            end
            mips_ctrl_pkg::st_fetch1: begin
                ctrl.pc_write = 1'b1;
                ctrl.ir_write = 1'b1;
                // PC+4 still on the ALU for the PC write
                ctrl.alu_srcb = mips_ctrl_pkg::srcb_four;
                ctrl.alu_op   = mips_ctrl_pkg::alu_add;
            end
            mips_ctrl_pkg::st_decode: begin
                ctrl.a_write  = 1'b1;
                ctrl.b_write  = 1'b1;
                ctrl.alu_srca = mips_ctrl_pkg::srca_pc;
                ctrl.alu_srcb = mips_ctrl_pkg::srcb_offset;
                ctrl.alu_op   = mips_ctrl_pkg::alu_add;
            end
            mips_ctrl_pkg::st_exec: begin
                ctrl.alu_srca      = mips_ctrl_pkg::srca_a;
                ctrl.alu_srcb      = mips_ctrl_pkg::srcb_b;
                ctrl.alu_reg_write = 1'b1;
                case (kind)
                    mips_isa_pkg::op_add: begin
                        ctrl.alu_op = mips_ctrl_pkg::alu_add;
                    end
                    mips_isa_pkg::op_sub: begin
                        ctrl.alu_op = mips_ctrl_pkg::alu_sub;
                    end
                    mips_isa_pkg::op_and: begin
                        ctrl.alu_op = mips_ctrl_pkg::alu_and;
                    end
                    default: begin
                        ctrl.alu_op = mips_ctrl_pkg::alu_none;
                    end
                endcase
            end
            mips_ctrl_pkg::st_writeback: begin
                // No write when the result overflowed
                if (!exc.valid) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.reg_dst   = mips_ctrl_pkg::dst_rd;
                    ctrl.mem_toreg = mips_ctrl_pkg::wb_alu;
                end
            end
            mips_ctrl_pkg::st_exc_wait: begin
                ctrl.iord   = mips_ctrl_pkg::iord_vector;
                ctrl.except = exc.code;
                ctrl.alu_op = mips_ctrl_pkg::alu_sub;
            end
            mips_ctrl_pkg::st_except: begin
                ctrl.epc_write = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_src    = mips_ctrl_pkg::pcsrc_vector;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== hw/control_sequencer.sv ====
module control_sequencer #(
    parameter int MEM_WAIT = 2,
    parameter int EXC_WAIT = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mips_isa_pkg::op_kind_t kind,
    input  logic                   ov,
    output mips_ctrl_pkg::state_t  state,
    output mips_ctrl_pkg::exc_t    exc,
    output mips_isa_pkg::op_kind_t exec_kind
);

    localparam int MAX_WAIT = (MEM_WAIT > EXC_WAIT) ? MEM_WAIT : EXC_WAIT;
    localparam int CNT_W    = (MAX_WAIT > 1) ? $clog2(MAX_WAIT) : 1;

    localparam logic [CNT_W-1:0] MEM_LAST = CNT_W'(MEM_WAIT - 1);
    localparam logic [CNT_W-1:0] EXC_LAST = CNT_W'(EXC_WAIT - 1);

    logic [CNT_W-1:0]    wait_cnt;
    mips_ctrl_pkg::exc_t exc_q;

    // Overflow is visible during write-back itself so the register write is dropped
    always_comb begin
        exc = exc_q;
        if (state == mips_ctrl_pkg::st_writeback && ov) begin
            exc.valid = 1'b1;
            exc.code  = mips_ctrl_pkg::exc_overflow;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= mips_ctrl_pkg::st_reset;
            wait_cnt <= '0;
            exc_q    <= '0;
        end else begin
            case (state)
                mips_ctrl_pkg::st_reset: begin
                    state <= mips_ctrl_pkg::st_fetch0;
                end
                mips_ctrl_pkg::st_fetch0: begin
                    if (wait_cnt == MEM_LAST) begin
                        wait_cnt <= '0;
                        state    <= mips_ctrl_pkg::st_fetch1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                mips_ctrl_pkg::st_fetch1: begin
                    state <= mips_ctrl_pkg::st_decode;
                end
                mips_ctrl_pkg::st_decode: begin
                    if (kind == mips_isa_pkg::op_undef) begin
                        exc_q.valid <= 1'b1;
                        exc_q.code  <= mips_ctrl_pkg::exc_noopcode;
                        state       <= mips_ctrl_pkg::st_exc_wait;
                    end else begin
                        state <= mips_ctrl_pkg::st_exec;
                    end
                end
                mips_ctrl_pkg::st_exec: begin
                    state <= mips_ctrl_pkg::st_writeback;
                end
                mips_ctrl_pkg::st_writeback: begin
                    if (ov) begin
                        exc_q.valid <= 1'b1;
                        exc_q.code  <= mips_ctrl_pkg::exc_overflow;
                        state       <= mips_ctrl_pkg::st_exc_wait;
                    end else begin
                        state <= mips_ctrl_pkg::st_fetch0;
                    end
                end
                mips_ctrl_pkg::st_exc_wait: begin
                    if (wait_cnt == EXC_LAST) begin
                        wait_cnt <= '0;
                        state    <= mips_ctrl_pkg::st_except;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                mips_ctrl_pkg::st_except: begin
                    exc_q.valid <= 1'b0;
                    state       <= mips_ctrl_pkg::st_fetch0;
                end
                default: begin
                    state <= mips_ctrl_pkg::st_reset;
                end
            endcase
        end
    end

    // Operation held from decode through write-back
    always_ff @(posedge clk) begin
        if (state == mips_ctrl_pkg::st_decode) begin
            exec_kind <= kind;
        end
    end

endmodule

// ==== hw/instr_decoder.sv ====
module instr_decoder (
    input  mips_isa_pkg::opcode_t  opcode,
    input  mips_isa_pkg::funct_t   funct,
    output mips_isa_pkg::op_kind_t kind
);

    always_comb begin
        kind = mips_isa_pkg::op_undef;
        if (opcode == mips_isa_pkg::OP_RTYPE) begin
            case (funct)
                mips_isa_pkg::FN_ADD: begin
                    kind = mips_isa_pkg::op_add;
                end
                mips_isa_pkg::FN_SUB: begin
                    kind = mips_isa_pkg::op_sub;
                end
                mips_isa_pkg::FN_AND: begin
                    kind = mips_isa_pkg::op_and;
                end
                // Remaining R-type codes are not implemented
                default: begin
                    kind = mips_isa_pkg::op_undef;
                end
            endcase
        end
    end

endmodule

// ==== hw/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

    typedef enum logic [3:0] {
        st_reset     = 4'd0,
        st_fetch0    = 4'd1,
        st_fetch1    = 4'd2,
        st_decode    = 4'd3,
        st_exec      = 4'd4,
        st_writeback = 4'd5,
        st_exc_wait  = 4'd6,
        st_except    = 4'd7
    } state_t;

    typedef enum logic [2:0] {
        alu_none = 3'b000,
        alu_add  = 3'b001,
        alu_and  = 3'b010,
        alu_sub  = 3'b011
    } alu_op_t;

    typedef enum logic [1:0] {
        srca_pc = 2'b00,
        srca_a  = 2'b01
    } alu_srca_t;

    typedef enum logic [2:0] {
        srcb_b      = 3'b000,
        srcb_four   = 3'b001,
        srcb_offset = 3'b011
    } alu_srcb_t;

    // Memory address select
    typedef enum logic [2:0] {
        iord_pc     = 3'b000,
        iord_alu    = 3'b001,
        iord_vector = 3'b010
    } iord_t;

    typedef enum logic [2:0] {
        pcsrc_alu    = 3'b000,
        pcsrc_vector = 3'b011
    } pc_src_t;

    typedef enum logic [1:0] {
        dst_rt = 2'b00,
        dst_rd = 2'b01,
        dst_sp = 2'b10
    } reg_dst_t;

    // Register file write-data select
    typedef enum logic [3:0] {
        wb_alu       = 4'b0000,
        wb_stack_top = 4'b0100
    } mem_toreg_t;

    typedef enum logic [1:0] {
        exc_noopcode = 2'b00,
        exc_overflow = 2'b01
    } exc_code_t;

    typedef struct packed {
        logic       pc_write;
        logic       ir_write;
        logic       a_write;
        logic       b_write;
        logic       alu_reg_write;
        logic       epc_write;
        logic       reg_write;
        alu_srca_t  alu_srca;
        alu_srcb_t  alu_srcb;
        alu_op_t    alu_op;
        iord_t      iord;
        pc_src_t    pc_src;
        reg_dst_t   reg_dst;
        mem_toreg_t mem_toreg;
        exc_code_t  except;
    } ctrl_word_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
    } exc_t;

endpackage

// ==== hw/mips_isa_pkg.sv ====
package mips_isa_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;

    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT_W-1:0]  funct_t;

    // R-type instructions share opcode zero
    localparam opcode_t OP_RTYPE = 6'h00;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;

    // Operation classes seen by the control path
    typedef enum logic [1:0] {
        op_add   = 2'd0,
        op_sub   = 2'd1,
        op_and   = 2'd2,
        op_undef = 2'd3
    } op_kind_t;

endpackage
